// ==== vlog.f ====
+incdir+include
logic/div_pkg.sv
logic/div_operand_prep.sv
logic/div_iter_core.sv
logic/div_result_fix.sv
logic/div_ctrl.sv
logic/div_unit.sv
verif/div_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

top=div_unit_tb
log=sim.log

verilator --binary --timing --assert --top-module "$top" -f vlog.f -o sim_div
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_div > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTS PASSED$" "$log"; then
    exit 0
fi
exit 1

// ==== include/div_tb_model.svh ====
`ifndef DIV_TB_MODEL_SVH
`define DIV_TB_MODEL_SVH

// expected RISC-V M-extension divide result
function automatic logic [63:0] div_model(input div_pkg::div_op_e op,
                                          input logic [63:0] a, input logic [63:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [31:0] wa;
    logic signed [31:0] wb;
    logic signed [63:0] sq;
    logic signed [63:0] sr;
    logic signed [31:0] wq;
    logic signed [31:0] wr;
    logic        [31:0] w;
    logic        [63:0] r;
    logic               ovf;
    logic               wovf;
    sa   = a;
    sb   = b;
    wa   = a[31:0];
    wb   = b[31:0];
    ovf  = (a == 64'h8000_0000_0000_0000) && (b == '1);
    wovf = (a[31:0] == 32'h8000_0000) && (b[31:0] == '1);
    sq   = '0;
    sr   = '0;
    wq   = '0;
    wr   = '0;
    w    = '0;
    r    = '0;
    // signed results kept apart so that they stay signed divisions
    if (b != 0 && !ovf) begin
        sq = sa / sb;
        sr = sa % sb;
    end
    if (b[31:0] != 0 && !wovf) begin
        wq = wa / wb;
        wr = wa % wb;
    end
    case (op)
        div_pkg::op_div:   r = (b == 0) ? '1 : ovf ? 64'h8000_0000_0000_0000 : sq;
        div_pkg::op_divu:  r = (b == 0) ? '1 : a / b;
        div_pkg::op_rem:   r = (b == 0) ? a : ovf ? '0 : sr;
        div_pkg::op_remu:  r = (b == 0) ? a : a % b;
        div_pkg::op_divw:  w = (b[31:0] == 0) ? '1 : wovf ? 32'h8000_0000 : wq;
        div_pkg::op_divuw: w = (b[31:0] == 0) ? '1 : a[31:0] / b[31:0];
        div_pkg::op_remw:  w = (b[31:0] == 0) ? a[31:0] : wovf ? '0 : wr;
        div_pkg::op_remuw: w = (b[31:0] == 0) ? a[31:0] : a[31:0] % b[31:0];
        default:           r = '0;
    endcase
    if (op inside {div_pkg::op_divw, div_pkg::op_divuw, div_pkg::op_remw, div_pkg::op_remuw}) begin
        r = {{32{w[31]}}, w};
    end
    return r;
endfunction

// true when the unit bypasses the core and answers in one cycle
function automatic logic div_model_special(input div_pkg::div_op_e op,
                                           input logic [63:0] a, input logic [63:0] b);
    logic word;
    logic sgn;
    word = op inside {div_pkg::op_divw, div_pkg::op_divuw, div_pkg::op_remw, div_pkg::op_remuw};
    sgn  = op inside {div_pkg::op_div, div_pkg::op_rem, div_pkg::op_divw, div_pkg::op_remw};
    if (word) begin
        return (b[31:0] == 0) || (sgn && a[31:0] == 32'h8000_0000 && b[31:0] == '1);
    end
    return (b == 0) || (sgn && a == 64'h8000_0000_0000_0000 && b == '1);
endfunction

`endif

// ==== verif/div_unit_tb.sv ====
module div_unit_tb import div_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    `include "div_tb_model.svh"

    localparam int clk_period      = 100;
    localparam int reset_cycles    = 16;
    localparam int normal_latency  = 66;
    localparam int special_latency = 1;
    localparam int resp_wait_max   = 100;
    // about 70 operations of at most 70 cycles plus reset, with margin
    localparam int timeout_cycles  = 7500;

    logic      clk;
    logic      rst;
    logic      req_valid;
    div_req_t  req;
    logic      flush;
    logic      ready;
    logic      resp_valid;
    div_resp_t resp;

    int          value_errs      = 0;
    int          latency_errs    = 0;
    int          missing_errs    = 0;
    int          unexpected_errs = 0;
    int          timeout_count   = 0;
    logic [63:0] lcg_state       = 64'd1;

    div_unit dut (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .flush      (flush),
        .ready      (ready),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        while (timeout_count < timeout_cycles) begin
            @(posedge clk);
            timeout_count++;
        end
        $display("simulation stopped after %0d cycles before the tests finished", timeout_count);
        $display("TESTS FAILED");
        $finish;
    end

    function automatic logic [63:0] lcg_next();
        lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
        return lcg_state;
    endfunction

    task automatic check_resp(input div_resp_t got, input div_resp_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("Error at %0t ns: got %h for %s, expected %h for %s",
                     $time, got.result, got.op.name(), exp.result, exp.op.name());
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            latency_errs++;
            $display("Error at %0t ns: response after %0d cycles, expected %0d",
                     $time, got, exp);
        end
    endtask

    // starts at a falling edge, returns at the falling edge of cycle 1
    task automatic send(input div_op_e op, input logic [63:0] a, input logic [63:0] b);
        req.op       = op;
        req.dividend = a;
        req.divisor  = b;
        req_valid    = 1'b1;
        @(posedge clk);
        @(negedge clk);
        req_valid = 1'b0;
        flush     = 1'b0;
    endtask

    task automatic collect(input div_resp_t exp, input int exp_lat);
        int cycles;
        cycles = 1;
        while (!resp_valid && cycles < resp_wait_max) begin
            if (ready) begin
                latency_errs++;
                $display("Error at %0t ns: ready high in cycle %0d of an operation",
                         $time, cycles);
            end
            @(negedge clk);
            cycles++;
        end
        if (!resp_valid) begin
            missing_errs++;
            $display("no response to %s arrived within %0d cycles", exp.op.name(), cycles);
        end else begin
            check_resp(resp, exp);
            check_latency(cycles, exp_lat);
            @(negedge clk);
            if (resp_valid) begin
                unexpected_errs++;
                $display("response pulse at %0t ns lasted more than one cycle", $time);
            end
            if (!ready) begin
                latency_errs++;
                $display("Error at %0t ns: ready still low after the response", $time);
            end
        end
    endtask

    task automatic run_op(input div_op_e op, input logic [63:0] a, input logic [63:0] b);
        div_resp_t exp;
        exp.result = div_model(op, a, b);
        exp.op     = op;
        send(op, a, b);
        collect(exp, div_model_special(op, a, b) ? special_latency : normal_latency);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            if (resp_valid) begin
                unexpected_errs++;
                $display("unexpected response at %0t ns with result %h", $time, resp.result);
            end
        end
    endtask

    task automatic test_unsigned();
        run_op(op_divu, 64'd100, 64'd7);
        run_op(op_remu, 64'd100, 64'd7);
        run_op(op_divu, 64'd5, 64'd1000);
        run_op(op_remu, 64'd5, 64'd1000);
        run_op(op_divu, '1, '1);
        run_op(op_remu, '1, 64'd3);
        run_op(op_divu, '1, 64'd1);
        run_op(op_remu, 64'h0123_4567_89ab_cdef, 64'h1000);
    endtask

    task automatic test_signed();
        logic [63:0] dvd [4];
        logic [63:0] dvs [4];
        dvd = '{64'd100, -64'd100, 64'd100, -64'd100};
        dvs = '{64'd7, 64'd7, -64'd7, -64'd7};
        for (int i = 0; i < 4; i++) begin
            run_op(op_div, dvd[i], dvs[i]);
            run_op(op_rem, dvd[i], dvs[i]);
        end
        // truncation toward zero
        run_op(op_div, -64'd1, 64'd2);
    endtask

    task automatic test_word();
        run_op(op_divw, 64'hdead_beef_0000_0064, 64'h1234_5678_ffff_fff9);
        run_op(op_remw, 64'hdead_beef_ffff_ff9c, 64'hcafe_f00d_0000_0007);
        run_op(op_divuw, 64'hdead_beef_ffff_ff9c, 64'h5555_aaaa_0000_0007);
        run_op(op_remuw, 64'hdead_beef_ffff_ff9c, 64'h5555_aaaa_0000_0007);
        run_op(op_divw, 64'h0000_0001_8000_0001, 64'hffff_ffff_0000_0002);
        run_op(op_remuw, 64'hffff_ffff_0000_0005, 64'h0000_0001_ffff_ffff);
    endtask

    task automatic test_special();
        for (int i = 0; i < 8; i++) begin
            // W forms see a zero low word despite the upper garbage
            if (i >= 4) begin
                run_op(div_op_e'(i), 64'h1234_5678_9abc_def0, 64'hffff_ffff_0000_0000);
            end else begin
                run_op(div_op_e'(i), 64'h1234_5678_9abc_def0, 64'd0);
            end
        end
        run_op(op_div, 64'h8000_0000_0000_0000, '1);
        run_op(op_rem, 64'h8000_0000_0000_0000, '1);
        run_op(op_divw, 64'h1234_5678_8000_0000, 64'h0000_0000_ffff_ffff);
        run_op(op_remw, 64'h1234_5678_8000_0000, 64'h0000_0000_ffff_ffff);
        // same bits through an unsigned op go the normal way
        run_op(op_divu, 64'h8000_0000_0000_0000, '1);
    endtask

    task automatic test_flush();
        div_resp_t exp;
        send(op_div, 64'd1000, 64'd3);
        idle_cycles(20);
        flush = 1'b1;
        @(posedge clk);
        @(negedge clk);
        flush = 1'b0;
        if (!ready) begin
            latency_errs++;
            $display("Error at %0t ns: ready low in the cycle after a flush", $time);
        end
        idle_cycles(70);
        // replace a running operation with a new one
        send(op_divu, 64'd1000, 64'd3);
        idle_cycles(30);
        flush = 1'b1;
        exp.result = div_model(op_remu, 64'd1000, 64'd7);
        exp.op     = op_remu;
        send(op_remu, 64'd1000, 64'd7);
        collect(exp, normal_latency);
    endtask

    task automatic test_random();
        logic [63:0] r;
        logic [63:0] a;
        logic [63:0] b;
        repeat (40) begin
            r = lcg_next();
            a = lcg_next();
            b = lcg_next();
            run_op(div_op_e'(r[63:61]), a, b >> r[10:5]);
        end
    endtask

    initial begin
        rst       = 1'b1;
        req_valid = 1'b0;
        flush     = 1'b0;
        req       = '0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (!ready || resp_valid) begin
            unexpected_errs++;
            $display("unit is not idle and ready after reset");
        end
        test_unsigned();
        test_signed();
        test_word();
        test_special();
        test_flush();
        test_random();
        $display("value errors %0d, latency errors %0d, missing %0d, unexpected %0d",
                 value_errs, latency_errs, missing_errs, unexpected_errs);
        if (value_errs + latency_errs + missing_errs + unexpected_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== logic/div_unit.sv ====
module div_unit import div_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      req_valid,
    input  div_req_t  req,
    input  logic      flush,
    output logic      ready,
    output logic      resp_valid,
    output div_resp_t resp
);

    div_prep_t       prep;
    div_prep_t       prep_held;
    logic            core_start;
    logic            core_done;
    logic [xlen-1:0] core_dividend;
    logic [xlen-1:0] core_divisor;
    logic [xlen-1:0] core_quotient;
    logic [xlen-1:0] core_remainder;
    logic [xlen-1:0] fixed_result;

    div_operand_prep u_prep (
        .req  (req),
        .prep (prep)
    );

    div_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req           (req),
        .flush         (flush),
        .prep_in       (prep),
        .core_done     (core_done),
        .fixed_result  (fixed_result),
        .ready         (ready),
        .core_start    (core_start),
        .core_dividend (core_dividend),
        .core_divisor  (core_divisor),
        .prep_held     (prep_held),
        .resp_valid    (resp_valid),
        .resp          (resp)
    );

    // busy is only watched inside the core
    div_iter_core #(
        .WIDTH (xlen)
    ) u_core (
        .clk       (clk),
        .rst       (rst),
        .start     (core_start),
        .flush     (flush),
        .dividend  (core_dividend),
        .divisor   (core_divisor),
        .busy      (),
        .done      (core_done),
        .quotient  (core_quotient),
        .remainder (core_remainder)
    );

    div_result_fix u_fix (
        .prep      (prep_held),
        .quotient  (core_quotient),
        .remainder (core_remainder),
        .result    (fixed_result)
    );

endmodule

// ==== logic/div_ctrl.sv ====
module div_ctrl import div_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            req_valid,
    input  div_req_t        req,
    input  logic            flush,
    input  div_prep_t       prep_in,
    input  logic            core_done,
    input  logic [xlen-1:0] fixed_result,
    output logic            ready,
    output logic            core_start,
    output logic [xlen-1:0] core_dividend,
    output logic [xlen-1:0] core_divisor,
    output div_prep_t       prep_held,
    output logic            resp_valid,
    output div_resp_t       resp
);

    div_state_e state_q;
    div_state_e state_d;
    div_prep_t  prep_q;
    div_op_e    op_q;
    div_resp_t  resp_q;
    logic       ready_q;
    logic       resp_valid_q;
    logic       accept;
    logic       special_in;

    // flush lets a new request in even while an old one runs
    assign accept     = req_valid && (ready_q || flush);
    assign special_in = prep_in.div_zero || prep_in.overflow;

    // the core loads straight from preparation in the accept cycle
    assign core_start    = accept && !special_in;
    assign core_dividend = prep_in.dvd_mag;
    assign core_divisor  = prep_in.dvs_mag;

    // special cases are resolved in the accept cycle, before prep_q is loaded
    assign prep_held = accept ? prep_in : prep_q;

    always_comb begin
        state_d = state_q;
        if (accept) begin
            state_d = special_in ? st_resp : st_busy;
        end else if (flush) begin
            state_d = st_idle;
        end else begin
            case (state_q)
                st_idle: state_d = st_idle;
                st_busy: begin
                    if (core_done) begin
                        state_d = st_resp;
                    end
                end
                st_resp: state_d = st_idle;
                default: state_d = st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q      <= st_idle;
            ready_q      <= 1'b1;
            resp_valid_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            ready_q      <= (state_d == st_idle);
            resp_valid_q <= (state_d == st_resp);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            prep_q <= prep_in;
            op_q   <= req.op;
        end
        // capture the result on entry to st_resp
        if (state_d == st_resp) begin
            resp_q.result <= fixed_result;
            resp_q.op     <= accept ? req.op : op_q;
        end
    end

    assign ready      = ready_q;
    assign resp_valid = resp_valid_q;
    assign resp       = resp_q;

    a_resp_single_cycle: assert property (
        @(posedge clk) disable iff (rst) resp_valid |=> !resp_valid
    );

    a_busy_not_ready: assert property (
        @(posedge clk) disable iff (rst) (state_q == st_busy) |-> !ready
    );

endmodule

// ==== logic/div_result_fix.sv ====
module div_result_fix import div_pkg::*; (
    input  div_prep_t       prep,
    input  logic [xlen-1:0] quotient,
    input  logic [xlen-1:0] remainder,
    output logic [xlen-1:0] result
);

    logic [xlen-1:0] quo_signed;
    logic [xlen-1:0] rem_signed;
    logic [xlen-1:0] quo_final;
    logic [xlen-1:0] rem_final;
    logic [xlen-1:0] chosen;

    // core works on magnitudes, put the signs back
    assign quo_signed = prep.quo_neg ? (~quotient + 1'b1) : quotient;
    assign rem_signed = prep.rem_neg ? (~remainder + 1'b1) : remainder;

    always_comb begin
        if (prep.div_zero) begin
            // quotient is all ones, remainder is the dividend
            quo_final = '1;
            rem_final = prep.dividend;
        end else if (prep.overflow) begin
            // the most negative value is the dividend itself,
            // already extended for the W forms
            quo_final = prep.dividend;
            rem_final = '0;
        end else begin
            quo_final = quo_signed;
            rem_final = rem_signed;
        end
    end

    assign chosen = prep.want_rem ? rem_final : quo_final;

    // W results are the low word sign extended
    assign result = prep.word ? {{32{chosen[31]}}, chosen[31:0]} : chosen;

endmodule

// ==== logic/div_iter_core.sv ====
module div_iter_core #(
    parameter int WIDTH = 64
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  logic             flush,
    input  logic [WIDTH-1:0] dividend,
    input  logic [WIDTH-1:0] divisor,
    output logic             busy,
    output logic             done,
    output logic [WIDTH-1:0] quotient,
    output logic [WIDTH-1:0] remainder
);

    localparam int CNT_W = $clog2(WIDTH);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(WIDTH - 1);

    // upper half holds the partial remainder, lower half collects quotient bits
    logic [2*WIDTH-1:0] part_q;
    // divisor aligned to the upper half
    logic [2*WIDTH-1:0] dvs_q;
    logic [CNT_W-1:0]   cnt_q;

    // one extra bit so a large partial remainder is not lost in the shift
    logic [2*WIDTH:0]   shifted;
    logic [2*WIDTH:0]   diff;
    logic               fits;
    logic [2*WIDTH-1:0] part_d;

    assign shifted = {part_q, 1'b0};
    assign diff    = shifted - {1'b0, dvs_q};
    assign fits    = (shifted >= {1'b0, dvs_q});

    // subtracting sets the new quotient bit, the low half of dvs_q is zero
    assign part_d = fits ? {diff[2*WIDTH-1:1], 1'b1} : shifted[2*WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            cnt_q <= '0;
        end else if (start) begin
            busy  <= 1'b1;
            done  <= 1'b0;
            cnt_q <= '0;
        end else if (flush) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            cnt_q <= '0;
        end else if (busy) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == LAST) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end else begin
            done <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            part_q <= {{WIDTH{1'b0}}, dividend};
            dvs_q  <= {divisor, {WIDTH{1'b0}}};
        end else if (busy && !flush) begin
            part_q <= part_d;
        end
    end

    assign quotient  = part_q[WIDTH-1:0];
    assign remainder = part_q[2*WIDTH-1:WIDTH];

    // an aborted division must not complete on the following edge
    a_no_done_after_flush: assert property (
        @(posedge clk) disable iff (rst) $rose(done) |-> !$past(flush)
    );

    // the controller only restarts a running division through a flush
    a_start_when_idle: assert property (
        @(posedge clk) disable iff (rst) start |-> (!busy || flush)
    );

endmodule

// ==== logic/div_operand_prep.sv ====
module div_operand_prep import div_pkg::*; (
    input  div_req_t  req,
    output div_prep_t prep
);

    logic            is_signed;
    logic            is_word;
    logic            is_rem;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic            neg_a;
    logic            neg_b;
    logic [xlen-1:0] min_val;

    always_comb begin
        is_signed = 1'b0;
        is_word   = 1'b0;
        is_rem    = 1'b0;
        case (req.op)
            op_div:   is_signed = 1'b1;
            op_divu:  ;
            op_rem: begin
                is_signed = 1'b1;
                is_rem    = 1'b1;
            end
            op_remu:  is_rem = 1'b1;
            op_divw: begin
                is_signed = 1'b1;
                is_word   = 1'b1;
            end
            op_divuw: is_word = 1'b1;
            op_remw: begin
                is_signed = 1'b1;
                is_word   = 1'b1;
                is_rem    = 1'b1;
            end
            op_remuw: begin
                is_word = 1'b1;
                is_rem  = 1'b1;
            end
            default:  ;
        endcase
    end

    // W forms look only at the low word, extended by the signedness of the op
    always_comb begin
        if (is_word) begin
            op_a = {{32{is_signed & req.dividend[31]}}, req.dividend[31:0]};
            op_b = {{32{is_signed & req.divisor[31]}}, req.divisor[31:0]};
        end else begin
            op_a = req.dividend;
            op_b = req.divisor;
        end
    end

    assign neg_a = is_signed && op_a[xlen-1];
    assign neg_b = is_signed && op_b[xlen-1];

    // most negative dividend as it looks after extension
    assign min_val = is_word ? {{33{1'b1}}, 31'd0} : {1'b1, {(xlen-1){1'b0}}};

    always_comb begin
        prep.dvd_mag  = neg_a ? (~op_a + 1'b1) : op_a;
        prep.dvs_mag  = neg_b ? (~op_b + 1'b1) : op_b;
        prep.quo_neg  = neg_a ^ neg_b;
        prep.rem_neg  = neg_a;
        prep.want_rem = is_rem;
        prep.word     = is_word;
        prep.div_zero = (op_b == '0);
        prep.overflow = is_signed && (op_a == min_val) && (op_b == '1);
        prep.dividend = op_a;
    end

endmodule

// ==== logic/div_pkg.sv ====
package div_pkg;

    // data width of the execute stage
    localparam int xlen = 64;

    // M-extension divide operations, W forms operate on the low 32 bits
    typedef enum logic [2:0] {
        op_div   = 3'd0,
        op_divu  = 3'd1,
        op_rem   = 3'd2,
        op_remu  = 3'd3,
        op_divw  = 3'd4,
        op_divuw = 3'd5,
        op_remw  = 3'd6,
        op_remuw = 3'd7
    } div_op_e;

    // request from the issue side, 131 bits
    typedef struct packed {
        div_op_e           op;
        logic [xlen-1:0]   dividend;
        logic [xlen-1:0]   divisor;
    } div_req_t;

    // result back to writeback, op is echoed so the consumer can match it
    typedef struct packed {
        logic [xlen-1:0]   result;
        div_op_e           op;
    } div_resp_t;

    // prepared operation, everything the core and the fixup need
    typedef struct packed {
        // unsigned magnitudes fed to the iterative core
        logic [xlen-1:0]   dvd_mag;
        logic [xlen-1:0]   dvs_mag;
        // sign restoration
        logic              quo_neg;
        logic              rem_neg;
        // result selection
        logic              want_rem;
        logic              word;
        // architectural special cases
        logic              div_zero;
        logic              overflow;
        // extended dividend, needed for the div-by-zero remainder
        logic [xlen-1:0]   dividend;
    } div_prep_t;

    // controller states
    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_busy = 2'd1,
        st_resp = 2'd2
    } div_state_e;

endpackage
